// ==== common/qsys_pkg.sv ====
// Queue system shared definitions
package qsys_pkg;

    //////////////////////////////
    // Queue geometry

    localparam int num_egr_ports = 2;
    localparam int num_prios     = 2;
    localparam int num_queues    = num_egr_ports * num_prios;
    localparam int queue_id_w    = 2;
    localparam int port_w        = 1;
    localparam int prio_w        = 1;

    //////////////////////////////
    // Data and storage sizes

    localparam int data_w        = 32;
    localparam int queue_depth   = 32;
    localparam int occ_w         = 6;
    localparam int max_pkt_words = 16;
    localparam int blen_w        = 7;

    //////////////////////////////
    // Records

    // Carried on the first word of each packet
    typedef struct packed {
        logic [port_w-1:0] egr_port;
        logic [prio_w-1:0] prio;
        logic [blen_w-1:0] byte_len;
    } pkt_meta_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
    } queue_word_t;

    // One per stored packet
    typedef struct packed {
        pkt_meta_t meta;
    } pkt_desc_t;

    // Prio 1 lands on the odd queue of a port
    function automatic logic [queue_id_w-1:0] queue_of(
        input logic [port_w-1:0] port,
        input logic [prio_w-1:0] prio
    );
        return queue_id_w'(int'(port) * num_prios + int'(prio));
    endfunction

endpackage

// ==== queue_mem/word_fifo.sv ====
// Show-ahead FIFO
module word_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic                         core_clk_ifc,
    input  logic                         arst_n,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     head,
    output logic                         empty,
    output logic [$clog2(depth+1)-1:0]   count
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    // Storage array
    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // Head is visible before the pop
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

endmodule

// ==== queue_mem/queue_mem.sv ====
// Per-queue word and descriptor storage
module queue_mem (
    input  logic                            core_clk_ifc,
    input  logic                            arst_n,
    input  logic                            enq_valid,
    input  logic [qsys_pkg::queue_id_w-1:0] enq_queue,
    input  qsys_pkg::queue_word_t           enq_word,
    input  logic                            enq_desc_push,
    input  qsys_pkg::pkt_desc_t             enq_desc,
    input  logic                            reserve_valid,
    input  logic [qsys_pkg::queue_id_w-1:0] reserve_queue,
    input  logic [qsys_pkg::occ_w-1:0]      reserve_words,
    output logic [qsys_pkg::occ_w-1:0]      occupancy [qsys_pkg::num_queues],
    output logic [qsys_pkg::num_queues-1:0] desc_avail,
    input  logic                            deq_word,
    input  logic [qsys_pkg::queue_id_w-1:0] deq_queue,
    input  logic                            desc_pop,
    output qsys_pkg::queue_word_t           head_word [qsys_pkg::num_queues],
    output qsys_pkg::pkt_desc_t             head_desc [qsys_pkg::num_queues]
);
    import qsys_pkg::*;

    logic [num_queues-1:0] desc_empty;
    logic [occ_w-1:0]      occ_next [num_queues];

    //////////////////////////////
    // Queue storage

    for (genvar q = 0; q < num_queues; q++) begin : g_queue
        word_fifo #(
            .payload_t (queue_word_t),
            .depth     (queue_depth)
        ) word_q (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .push         (enq_valid && enq_queue == queue_id_w'(q)),
            .push_data    (enq_word),
            .pop          (deq_word && deq_queue == queue_id_w'(q)),
            .head         (head_word[q]),
            .empty        (),
            .count        ()
        );

        // Descriptor goes in with the last word
        word_fifo #(
            .payload_t (pkt_desc_t),
            .depth     (queue_depth)
        ) desc_q (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .push         (enq_desc_push && enq_queue == queue_id_w'(q)),
            .push_data    (enq_desc),
            .pop          (desc_pop && deq_queue == queue_id_w'(q)),
            .head         (head_desc[q]),
            .empty        (desc_empty[q]),
            .count        ()
        );
    end

    assign desc_avail = ~desc_empty;

    //////////////////////////////
    // Occupancy

    // Reserved words count as used until they leave on dequeue
    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            occ_next[q] = occupancy[q];
            if (reserve_valid && reserve_queue == queue_id_w'(q)) begin
                occ_next[q] = occ_next[q] + reserve_words;
            end
            if (deq_word && deq_queue == queue_id_w'(q)) begin
                occ_next[q] = occ_next[q] - 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '{default: '0};
        end else begin
            occupancy <= occ_next;
        end
    end

endmodule

// ==== hdl/cong_man.sv ====
// Congestion manager
module cong_man (
    input  logic                          core_clk_ifc,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic                          in_last,
    input  logic [qsys_pkg::data_w-1:0]   in_data,
    input  qsys_pkg::pkt_meta_t           in_meta,
    input  logic [qsys_pkg::occ_w-1:0]    occupancy [qsys_pkg::num_queues],
    output logic                          enq_valid,
    output logic [qsys_pkg::queue_id_w-1:0] enq_queue,
    output qsys_pkg::queue_word_t         enq_word,
    output logic                          enq_desc_push,
    output qsys_pkg::pkt_desc_t           enq_desc,
    output logic                          reserve_valid,
    output logic [qsys_pkg::queue_id_w-1:0] reserve_queue,
    output logic [qsys_pkg::occ_w-1:0]    reserve_words,
    output logic [15:0]                   drop_cnt
);
    import qsys_pkg::*;

    logic                  in_pkt;
    logic                  first;
    logic                  fits;
    logic [queue_id_w-1:0] new_queue;
    logic [occ_w-1:0]      new_words;
    logic                  cur_admit;
    logic [queue_id_w-1:0] cur_queue;
    pkt_meta_t             cur_meta;
    logic                  admit_now;
    logic [queue_id_w-1:0] queue_now;
    pkt_meta_t             meta_now;

    //////////////////////////////
    // Admit decision on the first word

    always_comb begin
        first     = in_valid && !in_pkt;
        new_queue = queue_of(in_meta.egr_port, in_meta.prio);
        // Bytes to words, rounded up
        new_words = occ_w'((int'(in_meta.byte_len) + 3) / 4);
        fits      = (int'(occupancy[new_queue]) + int'(new_words)) <= queue_depth;
        admit_now = first ? fits : cur_admit;
        queue_now = first ? new_queue : cur_queue;
        meta_now  = first ? in_meta : cur_meta;
    end

    // Room is claimed right away so the next packet sees it
    assign reserve_valid = first && fits;
    assign reserve_queue = new_queue;
    assign reserve_words = new_words;

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt        <= 1'b0;
            cur_admit     <= 1'b0;
            enq_valid     <= 1'b0;
            enq_desc_push <= 1'b0;
            drop_cnt      <= '0;
        end else begin
            if (in_valid) begin
                in_pkt <= !in_last;
            end
            if (first) begin
                cur_admit <= fits;
            end
            enq_valid     <= in_valid && admit_now;
            enq_desc_push <= in_valid && in_last && admit_now;
            if (first && !fits) begin
                drop_cnt <= drop_cnt + 16'd1;
            end
        end
    end

    //////////////////////////////
    // Word stage toward queue memory

    always_ff @(posedge core_clk_ifc) begin
        if (first) begin
            cur_queue <= new_queue;
            cur_meta  <= in_meta;
        end
        enq_queue <= queue_now;
        enq_word  <= '{data: in_data, last: in_last};
        enq_desc  <= '{meta: meta_now};
    end

endmodule

// ==== hdl/egress_sched.sv ====
// Egress scheduler
module egress_sched (
    input  logic                            core_clk_ifc,
    input  logic                            arst_n,
    input  logic [qsys_pkg::num_queues-1:0] desc_avail,
    input  qsys_pkg::queue_word_t           head_word [qsys_pkg::num_queues],
    input  qsys_pkg::pkt_desc_t             head_desc [qsys_pkg::num_queues],
    output logic                            deq_word,
    output logic [qsys_pkg::queue_id_w-1:0] deq_queue,
    output logic                            desc_pop,
    output logic                            out_valid,
    output logic                            out_last,
    output logic [qsys_pkg::data_w-1:0]     out_data,
    output qsys_pkg::pkt_meta_t             out_meta,
    input  logic                            out_ready
);
    import qsys_pkg::*;

    logic [port_w-1:0]     rr_port;
    logic [queue_id_w-1:0] cur_queue;
    logic                  pick_valid;
    logic [port_w-1:0]     pick_port;
    logic [queue_id_w-1:0] pick_queue;
    logic                  pick_fire;
    logic                  load;

    //////////////////////////////
    // Queue selection

    // Later hits overwrite earlier ones, so the preferred port and
    // then its high prio queue win
    always_comb begin
        pick_valid = 1'b0;
        pick_port  = '0;
        pick_queue = '0;
        for (int i = num_egr_ports - 1; i >= 0; i--) begin
            for (int p = 0; p < num_prios; p++) begin
                if (desc_avail[queue_of(port_w'((int'(rr_port) + i) % num_egr_ports),
                                        prio_w'(p))]) begin
                    pick_valid = 1'b1;
                    pick_port  = port_w'((int'(rr_port) + i) % num_egr_ports);
                    pick_queue = queue_of(pick_port, prio_w'(p));
                end
            end
        end
    end

    // The output register doubles as the lock on the current queue
    assign pick_fire = !out_valid && pick_valid;
    assign load      = pick_fire || (out_valid && out_ready && !out_last);
    assign deq_word  = load;
    assign deq_queue = out_valid ? cur_queue : pick_queue;
    assign desc_pop  = load && head_word[deq_queue].last;

    //////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            rr_port   <= '0;
            cur_queue <= '0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_valid && out_ready && out_last) begin
                out_valid <= 1'b0;
            end
            if (pick_fire) begin
                cur_queue <= pick_queue;
                rr_port   <= (int'(pick_port) == num_egr_ports - 1) ? '0 : pick_port + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (load) begin
            out_data <= head_word[deq_queue].data;
            out_last <= head_word[deq_queue].last;
        end
        if (pick_fire) begin
            out_meta <= head_desc[pick_queue].meta;
        end
    end

endmodule

// ==== hdl/queue_system.sv ====
// Router packet queue system
module queue_system (
    input  logic                        core_clk_ifc,
    input  logic                        arst_n,
    input  logic                        in_valid,
    input  logic                        in_last,
    input  logic [qsys_pkg::data_w-1:0] in_data,
    input  qsys_pkg::pkt_meta_t         in_meta,
    output logic                        out_valid,
    output logic                        out_last,
    output logic [qsys_pkg::data_w-1:0] out_data,
    output qsys_pkg::pkt_meta_t         out_meta,
    input  logic                        out_ready,
    output logic [15:0]                 drop_cnt
);
    import qsys_pkg::*;

    // Ingress side
    logic                  enq_valid;
    logic [queue_id_w-1:0] enq_queue;
    queue_word_t           enq_word;
    logic                  enq_desc_push;
    pkt_desc_t             enq_desc;
    logic                  reserve_valid;
    logic [queue_id_w-1:0] reserve_queue;
    logic [occ_w-1:0]      reserve_words;
    logic [occ_w-1:0]      occupancy [num_queues];

    // Egress side
    logic [num_queues-1:0] desc_avail;
    queue_word_t           head_word [num_queues];
    pkt_desc_t             head_desc [num_queues];
    logic                  deq_word;
    logic [queue_id_w-1:0] deq_queue;
    logic                  desc_pop;

    cong_man cong_man0 (
        .core_clk_ifc  (core_clk_ifc),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_last       (in_last),
        .in_data       (in_data),
        .in_meta       (in_meta),
        .occupancy     (occupancy),
        .enq_valid     (enq_valid),
        .enq_queue     (enq_queue),
        .enq_word      (enq_word),
        .enq_desc_push (enq_desc_push),
        .enq_desc      (enq_desc),
        .reserve_valid (reserve_valid),
        .reserve_queue (reserve_queue),
        .reserve_words (reserve_words),
        .drop_cnt      (drop_cnt)
    );

    queue_mem queue_mem0 (
        .core_clk_ifc  (core_clk_ifc),
        .arst_n        (arst_n),
        .enq_valid     (enq_valid),
        .enq_queue     (enq_queue),
        .enq_word      (enq_word),
        .enq_desc_push (enq_desc_push),
        .enq_desc      (enq_desc),
        .reserve_valid (reserve_valid),
        .reserve_queue (reserve_queue),
        .reserve_words (reserve_words),
        .occupancy     (occupancy),
        .desc_avail    (desc_avail),
        .deq_word      (deq_word),
        .deq_queue     (deq_queue),
        .desc_pop      (desc_pop),
        .head_word     (head_word),
        .head_desc     (head_desc)
    );

    egress_sched egress_sched0 (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .desc_avail   (desc_avail),
        .head_word    (head_word),
        .head_desc    (head_desc),
        .deq_word     (deq_word),
        .deq_queue    (deq_queue),
        .desc_pop     (desc_pop),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .out_ready    (out_ready)
    );

endmodule

// ==== tests/queue_checker.sv ====
// Output stream checker
module queue_checker (
    input logic                        core_clk_ifc,
    input logic                        out_valid,
    input logic                        out_last,
    input logic [qsys_pkg::data_w-1:0] out_data,
    input qsys_pkg::pkt_meta_t         out_meta,
    input logic                        out_ready,
    input logic [15:0]                 drop_cnt
);
    import qsys_pkg::*;

    // Entry holds meta, last flag and data
    logic [41:0]           exp_q [num_queues][$];
    string                 test_name  = "none";
    bit                    stall_mode = 1'b0;
    bit                    mid_pkt    = 1'b0;
    logic [queue_id_w-1:0] cur_q      = '0;
    int                    pending    = 0;
    int                    err_cnt    = 0;
    int                    test_errs  = 0;
    int                    test_words = 0;
    int                    test_pkts  = 0;
    int                    test_cnt   = 0;
    int                    word_cnt   = 0;

    //////////////////////////////
    // Reporting

    task automatic value_error(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("** Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        err_cnt++;
        test_errs++;
    endtask

    task automatic other_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        err_cnt++;
        test_errs++;
    endtask

    task automatic print_test_line();
        test_cnt++;
        $display("test %s: %s, %0d words, drop_cnt %0d", test_name,
                 (test_errs == 0) ? "ok" : "errors", test_words, drop_cnt);
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d words checked, %0d errors", test_cnt, word_cnt, err_cnt);
    endtask

    //////////////////////////////
    // Test control from the stimulus

    task automatic start_test(input string name, input bit stall);
        test_name  = name;
        stall_mode = stall;
        test_errs  = 0;
        test_words = 0;
        test_pkts  = 0;
        mid_pkt    = 1'b0;
    endtask

    task automatic expect_word(input logic [queue_id_w-1:0] q, input logic [41:0] entry);
        exp_q[q].push_back(entry);
        pending++;
    endtask

    task automatic check_reset();
        start_test("reset", 1'b0);
        if (out_valid !== 1'b0) begin
            value_error("out_valid", 64'd0, 64'(out_valid));
        end
        if (drop_cnt !== 16'd0) begin
            value_error("drop_cnt", 64'd0, 64'(drop_cnt));
        end
        print_test_line();
    endtask

    task automatic end_test(input int drops);
        if (drop_cnt != 16'(drops)) begin
            value_error("drop_cnt", 64'(drops), 64'(drop_cnt));
        end
        for (int i = 0; i < num_queues; i++) begin
            if (exp_q[i].size() != 0) begin
                other_error($sformatf("%0d words never left queue %0d", exp_q[i].size(), i));
            end
        end
        print_test_line();
    endtask

    //////////////////////////////
    // Word compare on each transfer

    always @(posedge core_clk_ifc) begin : watch
        logic [queue_id_w-1:0] q;
        logic [queue_id_w-1:0] hi_q;
        logic [41:0]           exp;
        if (out_valid && out_ready) begin
            q    = queue_id_w'(int'(out_meta.egr_port) * num_prios + int'(out_meta.prio));
            hi_q = queue_id_w'(int'(out_meta.egr_port) * num_prios + 1);
            if (mid_pkt && q != cur_q) begin
                other_error($sformatf("word of queue %0d inside a packet of queue %0d",
                                      q, cur_q));
            end
            if (!mid_pkt) begin
                // Every stalled packet is stored by the second pick
                if (stall_mode && test_pkts > 0 && out_meta.prio == 1'b0 &&
                    exp_q[hi_q].size() != 0) begin
                    value_error("prio at packet start", 64'd1, 64'd0);
                end
                test_pkts++;
            end
            if (exp_q[q].size() == 0) begin
                other_error($sformatf("unexpected word %h on queue %0d", out_data, q));
            end else begin
                exp = exp_q[q].pop_front();
                pending--;
                if (out_data != exp[31:0]) begin
                    value_error("data", 64'(exp[31:0]), 64'(out_data));
                end
                if (out_last != exp[32]) begin
                    value_error("last", 64'(exp[32]), 64'(out_last));
                end
                if (out_meta != exp[41:33]) begin
                    value_error("meta", 64'(exp[41:33]), 64'(out_meta));
                end
            end
            mid_pkt = !out_last;
            cur_q   = q;
            test_words++;
            word_cnt++;
        end
    end

endmodule

// ==== tests/queue_system_tb.sv ====
// Queue system testbench
module queue_system_tb;
    import qsys_pkg::*;

    logic              core_clk_ifc;
    logic              arst_n;
    logic              in_valid;
    logic              in_last;
    logic [data_w-1:0] in_data;
    pkt_meta_t         in_meta;
    logic              out_valid;
    logic              out_last;
    logic [data_w-1:0] out_data;
    pkt_meta_t         out_meta;
    logic              out_ready;
    logic [15:0]       drop_cnt;

    logic [31:0]       lfsr_state;
    logic [7:0]        pkt_tag;
    int                occ_model [num_queues];
    int                drops_pred;
    bit                aborted;

    //////////////////////////////
    // Clock, DUT and checker

    always #2 core_clk_ifc = ~core_clk_ifc;

    queue_system dut0 (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_data      (in_data),
        .in_meta      (in_meta),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .out_ready    (out_ready),
        .drop_cnt     (drop_cnt)
    );

    queue_checker chk0 (
        .core_clk_ifc (core_clk_ifc),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_meta     (out_meta),
        .out_ready    (out_ready),
        .drop_cnt     (drop_cnt)
    );

    //////////////////////////////
    // Helpers

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic next_cycle();
        @(posedge core_clk_ifc);
        #1;
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // Drives one packet and predicts its admission
    task automatic send_packet(input int port, input int prio, input int words,
                               input bit toggle, output logic [queue_id_w-1:0] q);
        pkt_meta_t   meta;
        logic [31:0] rnd;
        bit          admit;
        meta.egr_port = port[0];
        meta.prio     = prio[0];
        // Up to 3 bytes short of whole words
        meta.byte_len = blen_w'(words * 4 - int'(pkt_tag[1:0]));
        q     = queue_id_w'(port * num_prios + prio);
        admit = (occ_model[q] + words) <= queue_depth;
        if (admit) begin
            occ_model[q] += words;
        end else begin
            drops_pred++;
        end
        for (int i = 0; i < words; i++) begin
            rnd      = rand_bits(24);
            in_valid = 1'b1;
            in_last  = (i == words - 1);
            in_data  = {pkt_tag, rnd[23:0]};
            in_meta  = meta;
            if (toggle) begin
                rnd       = rand_bits(1);
                out_ready = rnd[0];
            end
            if (admit) begin
                chk0.expect_word(q, {meta, in_last, in_data});
            end
            next_cycle();
        end
        pkt_tag = pkt_tag + 8'd1;
    endtask

    task automatic wait_output_loaded();
        int cycles;
        cycles = 0;
        while (!out_valid && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        if (!out_valid) begin
            $display("Timeout: first stalled packet never reached the output register");
            aborted = 1'b1;
        end
    endtask

    task automatic drain_output();
        int cycles;
        cycles = 0;
        while ((chk0.pending != 0 || out_valid) && cycles < 2000) begin
            next_cycle();
            cycles++;
        end
        if (chk0.pending != 0 || out_valid) begin
            $display("Timeout: output did not go idle, %0d words still expected",
                     chk0.pending);
            aborted = 1'b1;
        end
    endtask

    //////////////////////////////
    // Tests from the input file

    task automatic run_tests();
        int                    fd;
        int                    n;
        int                    port;
        int                    prio;
        int                    words;
        string                 tok;
        string                 name;
        string                 mode;
        string                 line;
        bit                    stall;
        bit                    toggle;
        bit                    first_pkt;
        logic [queue_id_w-1:0] q;
        fd = $fopen("tests/queue_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/queue_input.txt");
            aborted = 1'b1;
            return;
        end
        stall  = 1'b0;
        toggle = 1'b0;
        while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "test") begin
                n = $fscanf(fd, "%s %s", name, mode);
                if (n != 2) begin
                    $display("Test line in tests/queue_input.txt lacks a name or mode");
                    aborted = 1'b1;
                end else begin
                    stall     = (mode == "stall");
                    toggle    = (mode == "toggle");
                    first_pkt = 1'b1;
                    for (int i = 0; i < num_queues; i++) begin
                        occ_model[i] = 0;
                    end
                    out_ready = !stall;
                    chk0.start_test(name, stall);
                end
            end else if (tok == "pkt") begin
                n = $fscanf(fd, "%d %d %d", port, prio, words);
                if (n != 3 || words < 1 || words > max_pkt_words) begin
                    $display("Packet line in tests/queue_input.txt is malformed");
                    aborted = 1'b1;
                end else begin
                    send_packet(port, prio, words, toggle, q);
                    if (stall && first_pkt) begin
                        // Its head word moves into the output register
                        drive_idle();
                        wait_output_loaded();
                        occ_model[q] -= 1;
                    end
                    first_pkt = 1'b0;
                end
            end else if (tok == "end") begin
                drive_idle();
                out_ready = 1'b1;
                drain_output();
                chk0.end_test(drops_pred);
            end else begin
                n = $fgets(line, fd);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        core_clk_ifc = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        in_data      = '0;
        in_meta      = '0;
        out_ready    = 1'b1;
        lfsr_state   = 32'd19;
        pkt_tag      = 8'd0;
        drops_pred   = 0;
        aborted      = 1'b0;
        repeat (3) @(posedge core_clk_ifc);
        #1;
        arst_n = 1'b1;
        next_cycle();
        chk0.check_reset();
        run_tests();
        chk0.report_totals();
        if (aborted || chk0.err_cnt != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

// ==== tests/queue_input.txt ====
# test <name> <mode: flow, toggle or stall>, then one pkt line per packet
# pkt <egress port> <prio> <length in words>, and end closes the test
test single_queue flow
pkt 0 1 3
pkt 0 1 1
pkt 0 1 16
pkt 0 1 5
end
test all_queues flow
pkt 0 0 4
pkt 1 1 2
pkt 0 1 7
pkt 1 0 1
pkt 1 1 9
pkt 0 0 3
pkt 1 0 6
pkt 0 1 2
end
test stall_fill stall
pkt 0 0 16
pkt 1 1 12
pkt 0 0 16
pkt 1 1 12
pkt 0 0 8
pkt 1 1 12
pkt 0 0 1
pkt 0 0 2
end
test priority stall
pkt 1 0 2
pkt 0 0 3
pkt 0 1 3
pkt 0 0 2
end
test ready_toggle toggle
pkt 1 0 5
pkt 0 1 8
pkt 1 0 3
pkt 0 0 12
pkt 1 1 4
pkt 0 1 6
end

// ==== sources.f ====
common/qsys_pkg.sv
queue_mem/word_fifo.sv
queue_mem/queue_mem.sv
hdl/cong_man.sv
hdl/egress_sched.sv
hdl/queue_system.sv
tests/queue_checker.sv
tests/queue_system_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vqueue_system_tb
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --timing -j 0 --top-module queue_system_tb -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
